// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ccip_sniffer \
		-Mdir build -f src.f
	out="$$(./build/Vtb_ccip_sniffer)"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf build

// ==== rtl/c0_req_checker.sv ====
`timescale 1ns/1ps

module c0_req_checker (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  logic                  c0_full,
   input  ccip_pkg::c0_tx_t      c0_tx,
   output sniff_pkg::sniff_vec_t flags
);
   import ccip_pkg::*;
   import sniff_pkg::*;

   sniff_vec_t flags_d;

   // All read rules are single beat, judged on the sampled request
   always_comb begin
      flags_d = '0;
      if (c0_tx.valid) begin
         // Only the two read-line flavours exist
         flags_d[SNIFF_C0TX_INVALID_REQTYPE] =
            !(c0_tx.hdr.req_type inside {RDLINE_I, RDLINE_S});

         // Request issued against a full channel
         flags_d[SNIFF_C0TX_OVERFLOW] = c0_full;

         // Accelerator held in reset but still issuing
         flags_d[SNIFF_C0TX_RESET_IGNORED] = soft_reset;

         // Three lines is the one length code with no meaning
         flags_d[SNIFF_C0TX_3CL_REQUEST] = (c0_tx.hdr.cl_len == CCIP_CLLEN_3);

         // Two-line reads start on an even line
         flags_d[SNIFF_C0TX_ADDRALIGN_2_ERROR] =
            (c0_tx.hdr.cl_len == CL_LEN_2) && c0_tx.hdr.address[0];

         // Four-line reads start on a multiple of four
         flags_d[SNIFF_C0TX_ADDRALIGN_4_ERROR] =
            (c0_tx.hdr.cl_len == CL_LEN_4) && (c0_tx.hdr.address[1:0] != 2'b00);

         // Line zero is never a valid buffer
         flags_d[SNIFF_C0TX_ADDR_ZERO] = (c0_tx.hdr.address == '0);
      end
   end

   // One-cycle pulse per violation
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         flags <= '0;
      end else begin
         flags <= flags_d;
      end
   end

endmodule

// ==== rtl/c1_mcl_checker.sv ====
`timescale 1ns/1ps

module c1_mcl_checker (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  logic                  c1_full,
   input  ccip_pkg::c1_tx_t      c1_tx,
   output sniff_pkg::sniff_vec_t flags
);
   import ccip_pkg::*;
   import sniff_pkg::*;

   // Encoding doubles as the beat index within a burst
   typedef enum logic [1:0] {
      EXP_FIRST = 2'd0,
      EXP_BEAT2 = 2'd1,
      EXP_BEAT3 = 2'd2,
      EXP_BEAT4 = 2'd3
   } exp_state_t;

   exp_state_t   state;
   exp_state_t   state_next;

   // Burst reference, taken from the first beat
   t_ccip_vc     base_vc;
   t_ccip_c1_req base_req;
   t_ccip_cllen  base_len;
   logic [1:0]   base_addr_lo;

   logic         is_fence;
   logic         data_beat;
   logic         first_beat;
   logic         later_beat;
   logic [1:0]   exp_addr_lo;
   sniff_vec_t   flags_d;

   assign is_fence   = c1_tx.valid && (c1_tx.hdr.req_type == WRFENCE);
   // Anything valid that is not a fence moves a line
   assign data_beat  = c1_tx.valid && !is_fence;
   assign first_beat = data_beat && (state == EXP_FIRST);
   assign later_beat = data_beat && (state != EXP_FIRST);

   // Low address bits step by one per beat, wrapping in two bits
   assign exp_addr_lo = base_addr_lo + state;

   always_comb begin
      flags_d = '0;
      if (c1_tx.valid) begin
         flags_d[SNIFF_C1TX_INVALID_REQTYPE] =
            !(c1_tx.hdr.req_type inside {WRLINE_I, WRLINE_M, WRPUSH_I, WRFENCE});
         flags_d[SNIFF_C1TX_OVERFLOW]      = c1_full;
         flags_d[SNIFF_C1TX_RESET_IGNORED] = soft_reset;
      end
      // Fence address is don't-care, so only write beats
      if (data_beat) begin
         flags_d[SNIFF_C1TX_ADDR_ZERO] = (c1_tx.hdr.address == '0);
      end
      // Length, alignment and sop belong to the opening beat
      if (first_beat) begin
         flags_d[SNIFF_C1TX_3CL_REQUEST] = (c1_tx.hdr.cl_len == CCIP_CLLEN_3);
         flags_d[SNIFF_C1TX_ADDRALIGN_2_ERROR] =
            (c1_tx.hdr.cl_len == CL_LEN_2) && c1_tx.hdr.address[0];
         flags_d[SNIFF_C1TX_ADDRALIGN_4_ERROR] =
            (c1_tx.hdr.cl_len == CL_LEN_4) && (c1_tx.hdr.address[1:0] != 2'b00);
         flags_d[SNIFF_C1TX_SOP_NOT_SET] = !c1_tx.hdr.sop;
      end
      // Beats two to four must repeat the opening beat
      if (later_beat) begin
         flags_d[SNIFF_C1TX_SOP_SET_MCL1TO3] = c1_tx.hdr.sop;
         flags_d[SNIFF_C1TX_UNEXP_VCSEL]     = (c1_tx.hdr.vc_sel != base_vc);
         flags_d[SNIFF_C1TX_UNEXP_REQTYPE]   = (c1_tx.hdr.req_type != base_req);
         flags_d[SNIFF_C1TX_UNEXP_ADDR]      = (c1_tx.hdr.address[1:0] != exp_addr_lo);
      end
      // Fence inside an open burst
      flags_d[SNIFF_C1TX_WRFENCE_IN_MCL1TO3] = is_fence && (state != EXP_FIRST);
   end

   // Fences never advance the burst
   always_comb begin
      state_next = state;
      case (state)
         EXP_FIRST: begin
            // Three-line writes are flagged and treated as single beats
            if (first_beat && (c1_tx.hdr.cl_len inside {CL_LEN_2, CL_LEN_4})) begin
               state_next = EXP_BEAT2;
            end
         end
         EXP_BEAT2: begin
            if (data_beat) begin
               state_next = (base_len == CL_LEN_4) ? EXP_BEAT3 : EXP_FIRST;
            end
         end
         EXP_BEAT3: begin
            if (data_beat) begin
               state_next = EXP_BEAT4;
            end
         end
         default: begin
            if (data_beat) begin
               state_next = EXP_FIRST;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         state <= EXP_FIRST;
         flags <= '0;
      end else begin
         state <= state_next;
         flags <= flags_d;
      end
   end

   // Burst reference capture
   always_ff @(posedge clk) begin
      if (first_beat) begin
         base_vc      <= c1_tx.hdr.vc_sel;
         base_req     <= c1_tx.hdr.req_type;
         base_len     <= c1_tx.hdr.cl_len;
         base_addr_lo <= c1_tx.hdr.address[1:0];
      end
   end

endmodule

// ==== rtl/ccip_pkg.sv ====
package ccip_pkg;

   // Request address and MMIO transaction ID sizes
   localparam int CCIP_CLADDR_WIDTH = 42;
   localparam int CCIP_TID_WIDTH    = 4;
   localparam int CCIP_MDATA_WIDTH  = 8;

   typedef logic [CCIP_CLADDR_WIDTH-1:0] t_ccip_claddr;
   typedef logic [CCIP_TID_WIDTH-1:0]    t_ccip_tid;
   typedef logic [CCIP_MDATA_WIDTH-1:0]  t_ccip_mdata;

   // Virtual channel select
   typedef logic [1:0] t_ccip_vc;

   // Line count of a request
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'b00,
      CL_LEN_2 = 2'b01,
      CL_LEN_4 = 2'b11
   } t_ccip_cllen;

   // Leftover encoding, a three-line request, never legal
   localparam logic [1:0] CCIP_CLLEN_3 = 2'b10;

   // Read request types
   typedef enum logic [3:0] {
      RDLINE_I = 4'h0,
      RDLINE_S = 4'h1
   } t_ccip_c0_req;

   // Write request types, fence included
   typedef enum logic [3:0] {
      WRLINE_I = 4'h0,
      WRLINE_M = 4'h1,
      WRPUSH_I = 4'h2,
      WRFENCE  = 4'h4
   } t_ccip_c1_req;

   typedef struct packed {
      t_ccip_vc     vc_sel;
      t_ccip_cllen  cl_len;
      t_ccip_c0_req req_type;
      t_ccip_claddr address;
      t_ccip_mdata  mdata;
   } t_ccip_c0_req_hdr;

   typedef struct packed {
      t_ccip_vc     vc_sel;
      logic         sop;
      t_ccip_cllen  cl_len;
      t_ccip_c1_req req_type;
      t_ccip_claddr address;
      t_ccip_mdata  mdata;
   } t_ccip_c1_req_hdr;

   // Read request channel
   typedef struct packed {
      logic             valid;
      t_ccip_c0_req_hdr hdr;
   } c0_tx_t;

   // Write and fence channel
   typedef struct packed {
      logic             valid;
      t_ccip_c1_req_hdr hdr;
   } c1_tx_t;

   // MMIO read response from the accelerator
   typedef struct packed {
      logic      mmio_rd_valid;
      t_ccip_tid tid;
   } c2_tx_t;

   // MMIO read request towards the accelerator
   typedef struct packed {
      logic      mmio_rd_valid;
      t_ccip_tid tid;
   } c0_rx_mmio_t;

endpackage

// ==== rtl/ccip_sniffer.sv ====
`timescale 1ns/1ps

module ccip_sniffer #(
   parameter int MMIO_TIMEOUT = 512
) (
   input  logic                     clk,
   input  logic                     ase_reset,
   input  logic                     init_sniffer,
   input  logic                     soft_reset,
   input  logic                     c0_full,
   input  logic                     c1_full,
   input  ccip_pkg::c0_tx_t         c0_tx,
   input  ccip_pkg::c1_tx_t         c1_tx,
   input  ccip_pkg::c2_tx_t         c2_tx,
   input  ccip_pkg::c0_rx_mmio_t    c0_rx_mmio,
   output sniff_pkg::sniff_report_t report,
   output sniff_pkg::sniff_vec_t    error_code
);
   import sniff_pkg::*;

   // Per-checker pulses, disjoint code sets
   sniff_vec_t c0_flags;
   sniff_vec_t c1_flags;
   sniff_vec_t mmio_flags;

   // Read request rules
   c0_req_checker c0_chk_i (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c0_full    (c0_full),
      .c0_tx      (c0_tx),
      .flags      (c0_flags)
   );

   // Write and burst rules
   c1_mcl_checker c1_chk_i (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c1_full    (c1_full),
      .c1_tx      (c1_tx),
      .flags      (c1_flags)
   );

   mmio_rsp_tracker #(
      .MMIO_TIMEOUT (MMIO_TIMEOUT)
   ) mmio_trk_i (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c0_rx_mmio (c0_rx_mmio),
      .c2_tx      (c2_tx),
      .flags      (mmio_flags)
   );

   // Single report bus plus sticky vector
   violation_arbiter arb_i (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .init_sniffer (init_sniffer),
      .c0_flags     (c0_flags),
      .c1_flags     (c1_flags),
      .mmio_flags   (mmio_flags),
      .report       (report),
      .error_code   (error_code)
   );

endmodule

// ==== rtl/mmio_rsp_tracker.sv ====
`timescale 1ns/1ps

module mmio_rsp_tracker #(
   parameter int MMIO_TIMEOUT = 512
) (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  ccip_pkg::c0_rx_mmio_t c0_rx_mmio,
   input  ccip_pkg::c2_tx_t      c2_tx,
   output sniff_pkg::sniff_vec_t flags
);
   import ccip_pkg::*;
   import sniff_pkg::*;

   // One entry per TID
   localparam int DEPTH = 2 ** CCIP_TID_WIDTH;
   localparam int CNT_W = $clog2(MMIO_TIMEOUT + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MMIO_TIMEOUT - 1);
   localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(MMIO_TIMEOUT);

   logic [DEPTH-1:0] active;
   logic [CNT_W-1:0] timer [DEPTH];
   logic [DEPTH-1:0] req_hit;
   logic [DEPTH-1:0] rsp_hit;
   logic [DEPTH-1:0] expire;
   sniff_vec_t       flags_d;

   // TID decode of request and response
   assign req_hit = c0_rx_mmio.mmio_rd_valid ? (DEPTH'(1) << c0_rx_mmio.tid) : '0;
   assign rsp_hit = c2_tx.mmio_rd_valid ? (DEPTH'(1) << c2_tx.tid) : '0;

   // Fires once, on the cycle the timer steps onto the limit
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         expire[i] = active[i] && (timer[i] == CNT_LAST) && !rsp_hit[i];
      end
   end

   always_comb begin
      flags_d = '0;
      flags_d[SNIFF_MMIO_RDRSP_TIMEOUT] = |expire;
      // Response to a TID with nothing outstanding
      flags_d[SNIFF_MMIO_RDRSP_UNSOLICITED] = |(rsp_hit & ~active);
      flags_d[SNIFF_MMIO_RDRSP_RESET_IGNORED] = c2_tx.mmio_rd_valid && soft_reset;
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         active <= '0;
         flags  <= '0;
         for (int i = 0; i < DEPTH; i++) begin
            timer[i] <= '0;
         end
      end else begin
         flags <= flags_d;
         for (int i = 0; i < DEPTH; i++) begin
            // A new request on the same TID restarts the count
            if (req_hit[i]) begin
               active[i] <= 1'b1;
               timer[i]  <= '0;
            end else if (rsp_hit[i]) begin
               active[i] <= 1'b0;
            end else if (active[i] && (timer[i] != CNT_MAX)) begin
               // Saturates so the timeout is raised only once
               timer[i] <= timer[i] + 1'b1;
            end
         end
      end
   end

endmodule

// ==== rtl/sniff_pkg.sv ====
package sniff_pkg;

   localparam int SNIFF_NUM_CODES = 23;

   // Violation codes, lower value wins arbitration
   typedef enum logic [4:0] {
      // Read request channel
      SNIFF_C0TX_INVALID_REQTYPE    = 5'd0,
      SNIFF_C0TX_OVERFLOW           = 5'd1,
      SNIFF_C0TX_ADDRALIGN_2_ERROR  = 5'd2,
      SNIFF_C0TX_ADDRALIGN_4_ERROR  = 5'd3,
      SNIFF_C0TX_RESET_IGNORED      = 5'd4,
      SNIFF_C0TX_3CL_REQUEST        = 5'd5,
      SNIFF_C0TX_ADDR_ZERO          = 5'd6,
      // Write channel, single beat rules
      SNIFF_C1TX_INVALID_REQTYPE    = 5'd7,
      SNIFF_C1TX_OVERFLOW           = 5'd8,
      SNIFF_C1TX_ADDRALIGN_2_ERROR  = 5'd9,
      SNIFF_C1TX_ADDRALIGN_4_ERROR  = 5'd10,
      SNIFF_C1TX_RESET_IGNORED      = 5'd11,
      SNIFF_C1TX_3CL_REQUEST        = 5'd12,
      SNIFF_C1TX_ADDR_ZERO          = 5'd13,
      // Write channel, burst rules
      SNIFF_C1TX_UNEXP_VCSEL        = 5'd14,
      SNIFF_C1TX_UNEXP_ADDR         = 5'd15,
      SNIFF_C1TX_UNEXP_REQTYPE      = 5'd16,
      SNIFF_C1TX_SOP_NOT_SET        = 5'd17,
      SNIFF_C1TX_SOP_SET_MCL1TO3    = 5'd18,
      SNIFF_C1TX_WRFENCE_IN_MCL1TO3 = 5'd19,
      // MMIO read responses
      SNIFF_MMIO_RDRSP_TIMEOUT      = 5'd20,
      SNIFF_MMIO_RDRSP_UNSOLICITED  = 5'd21,
      SNIFF_MMIO_RDRSP_RESET_IGNORED = 5'd22
   } sniff_code_t;

   // One bit per code, indexed by code value
   typedef logic [SNIFF_NUM_CODES-1:0] sniff_vec_t;

   // Serialized report, one code per strobe
   typedef struct packed {
      logic        valid;
      sniff_code_t code;
   } sniff_report_t;

endpackage

// ==== rtl/violation_arbiter.sv ====
`timescale 1ns/1ps

module violation_arbiter (
   input  logic                     clk,
   input  logic                     ase_reset,
   input  logic                     init_sniffer,
   input  sniff_pkg::sniff_vec_t    c0_flags,
   input  sniff_pkg::sniff_vec_t    c1_flags,
   input  sniff_pkg::sniff_vec_t    mmio_flags,
   output sniff_pkg::sniff_report_t report,
   output sniff_pkg::sniff_vec_t    error_code
);
   import sniff_pkg::*;

   sniff_vec_t  pending;
   sniff_vec_t  grant_onehot;
   sniff_code_t grant_code;

   // Lowest set bit, code 0 has top priority
   assign grant_onehot = pending & (~pending + 1'b1);

   // One-hot to code number
   always_comb begin
      grant_code = sniff_code_t'(5'd0);
      for (int i = 0; i < SNIFF_NUM_CODES; i++) begin
         if (grant_onehot[i]) begin
            grant_code = sniff_code_t'(i[$bits(sniff_code_t)-1:0]);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ase_reset || init_sniffer) begin
         pending    <= '0;
         error_code <= '0;
         report     <= '0;
      end else begin
         // Checker code sets are disjoint, repeats fold into the same bit
         pending <= (pending & ~grant_onehot) | c0_flags | c1_flags | mmio_flags;

         // Sticky record rises together with the strobe
         error_code <= error_code | grant_onehot;

         report.valid <= |pending;
         report.code  <= grant_code;
      end
   end

endmodule

// ==== src.f ====
rtl/ccip_pkg.sv
rtl/sniff_pkg.sv
rtl/c0_req_checker.sv
rtl/c1_mcl_checker.sv
rtl/mmio_rsp_tracker.sv
rtl/violation_arbiter.sv
rtl/ccip_sniffer.sv
tb/sniffer_props.sv
tb/tb_ccip_sniffer.sv

// ==== tb/sniffer_props.sv ====
`timescale 1ns/1ps

module sniffer_props (
   input logic                     clk,
   input logic                     ase_reset,
   input logic                     init_sniffer,
   input sniff_pkg::sniff_report_t report,
   input sniff_pkg::sniff_vec_t    error_code
);
   import sniff_pkg::*;

   // Running count of failed assertions
   int assert_fails = 0;

   // Report bus quiet while reset is applied
   quiet_in_reset: assert property (@(posedge clk) ase_reset |=> !report.valid)
      else begin
         assert_fails++;
         $error("report valid while in reset");
      end

   // Only defined codes on the bus
   code_in_range: assert property (@(posedge clk)
      report.valid |-> (int'(report.code) < SNIFF_NUM_CODES))
      else begin
         assert_fails++;
         $error("reported code out of range");
      end

   // Sticky bits only drop on reset or init
   sticky_holds: assert property (@(posedge clk)
      !(ase_reset || init_sniffer) |=> ((error_code & $past(error_code)) == $past(error_code)))
      else begin
         assert_fails++;
         $error("error_code bit cleared outside reset");
      end

endmodule

// ==== tb/tb_ccip_sniffer.sv ====
`timescale 1ns/1ps

module tb_ccip_sniffer;
   import ccip_pkg::*;
   import sniff_pkg::*;

   localparam int MMIO_TIMEOUT = 64;
   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 4;
   // Quiet cycles on the report bus that close a test
   localparam int DRAIN_IDLE   = 8;
   localparam int NUM_TESTS    = 26;
   // Longest test is the MMIO timeout one
   localparam int TEST_CYCLES  = 2 * MMIO_TIMEOUT + 64;
   localparam int RUN_LIMIT    = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD + 20000;
   localparam logic [31:0] SEED = 32'h2c85_ada2;

   // Everything driven into the DUT in one cycle
   typedef struct packed {
      logic        soft_reset;
      logic        c0_full;
      logic        c1_full;
      c0_tx_t      c0_tx;
      c1_tx_t      c1_tx;
      c2_tx_t      c2_tx;
      c0_rx_mmio_t c0_rx_mmio;
   } beat_t;

   logic          clk;
   logic          ase_reset;
   logic          init_sniffer;
   logic          soft_reset;
   logic          c0_full;
   logic          c1_full;
   c0_tx_t        c0_tx;
   c1_tx_t        c1_tx;
   c2_tx_t        c2_tx;
   c0_rx_mmio_t   c0_rx_mmio;
   sniff_report_t report;
   sniff_vec_t    error_code;

   // Stimulus of the running test and the codes it produced
   beat_t         beats[$];
   sniff_code_t   seen_codes[$];
   logic          collecting;
   string         test_name;
   int            tests_run;
   int            tests_failed;
   event          test_done;
   event          test_checked;

   ccip_sniffer #(
      .MMIO_TIMEOUT (MMIO_TIMEOUT)
   ) dut_i (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .init_sniffer (init_sniffer),
      .soft_reset   (soft_reset),
      .c0_full      (c0_full),
      .c1_full      (c1_full),
      .c0_tx        (c0_tx),
      .c1_tx        (c1_tx),
      .c2_tx        (c2_tx),
      .c0_rx_mmio   (c0_rx_mmio),
      .report       (report),
      .error_code   (error_code)
   );

   bind ccip_sniffer sniffer_props props_i (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .init_sniffer (init_sniffer),
      .report       (report),
      .error_code   (error_code)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Expected sticky vector, rules replayed over the beat list
   function automatic sniff_vec_t expected_codes();
      sniff_vec_t       exp_vec;
      beat_t            b;
      t_ccip_c0_req_hdr rh;
      t_ccip_c1_req_hdr wh;
      int               burst_len;
      int               beat_idx;
      t_ccip_vc         first_vc;
      t_ccip_c1_req     first_req;
      logic [1:0]       first_lo;
      logic [15:0]      waiting;
      int               asked_at [16];
      int               tid;
      exp_vec   = '0;
      burst_len = 1;
      beat_idx  = 0;
      first_vc  = '0;
      first_req = WRLINE_I;
      first_lo  = '0;
      waiting   = '0;
      foreach (beats[i]) begin
         b  = beats[i];
         rh = b.c0_tx.hdr;
         wh = b.c1_tx.hdr;
         if (b.c0_tx.valid) begin
            if (rh.req_type != RDLINE_I && rh.req_type != RDLINE_S)
               exp_vec[SNIFF_C0TX_INVALID_REQTYPE] = 1'b1;
            if (b.c0_full) exp_vec[SNIFF_C0TX_OVERFLOW] = 1'b1;
            if (b.soft_reset) exp_vec[SNIFF_C0TX_RESET_IGNORED] = 1'b1;
            if (rh.cl_len == CCIP_CLLEN_3) exp_vec[SNIFF_C0TX_3CL_REQUEST] = 1'b1;
            if (rh.cl_len == CL_LEN_2 && rh.address[0])
               exp_vec[SNIFF_C0TX_ADDRALIGN_2_ERROR] = 1'b1;
            if (rh.cl_len == CL_LEN_4 && rh.address[1:0] != 2'b00)
               exp_vec[SNIFF_C0TX_ADDRALIGN_4_ERROR] = 1'b1;
            if (rh.address == '0) exp_vec[SNIFF_C0TX_ADDR_ZERO] = 1'b1;
         end
         if (b.c1_tx.valid) begin
            if (!(wh.req_type inside {WRLINE_I, WRLINE_M, WRPUSH_I, WRFENCE}))
               exp_vec[SNIFF_C1TX_INVALID_REQTYPE] = 1'b1;
            if (b.c1_full) exp_vec[SNIFF_C1TX_OVERFLOW] = 1'b1;
            if (b.soft_reset) exp_vec[SNIFF_C1TX_RESET_IGNORED] = 1'b1;
            if (wh.req_type == WRFENCE) begin
               // Fences belong between bursts and never count as a beat
               if (beat_idx != 0) exp_vec[SNIFF_C1TX_WRFENCE_IN_MCL1TO3] = 1'b1;
            end else begin
               if (wh.address == '0) exp_vec[SNIFF_C1TX_ADDR_ZERO] = 1'b1;
               if (beat_idx == 0) begin
                  if (wh.cl_len == CCIP_CLLEN_3) exp_vec[SNIFF_C1TX_3CL_REQUEST] = 1'b1;
                  if (wh.cl_len == CL_LEN_2 && wh.address[0])
                     exp_vec[SNIFF_C1TX_ADDRALIGN_2_ERROR] = 1'b1;
                  if (wh.cl_len == CL_LEN_4 && wh.address[1:0] != 2'b00)
                     exp_vec[SNIFF_C1TX_ADDRALIGN_4_ERROR] = 1'b1;
                  if (!wh.sop) exp_vec[SNIFF_C1TX_SOP_NOT_SET] = 1'b1;
                  first_vc  = wh.vc_sel;
                  first_req = wh.req_type;
                  first_lo  = wh.address[1:0];
                  burst_len = (wh.cl_len == CL_LEN_2) ? 2 : ((wh.cl_len == CL_LEN_4) ? 4 : 1);
                  beat_idx  = (burst_len > 1) ? 1 : 0;
               end else begin
                  if (wh.sop) exp_vec[SNIFF_C1TX_SOP_SET_MCL1TO3] = 1'b1;
                  if (wh.vc_sel != first_vc) exp_vec[SNIFF_C1TX_UNEXP_VCSEL] = 1'b1;
                  if (wh.req_type != first_req) exp_vec[SNIFF_C1TX_UNEXP_REQTYPE] = 1'b1;
                  if (wh.address[1:0] != first_lo + 2'(beat_idx))
                     exp_vec[SNIFF_C1TX_UNEXP_ADDR] = 1'b1;
                  beat_idx = (beat_idx + 1 == burst_len) ? 0 : beat_idx + 1;
               end
            end
         end
         // Response judged before a request on the same beat
         if (b.c2_tx.mmio_rd_valid) begin
            tid = int'(b.c2_tx.tid);
            if (b.soft_reset) exp_vec[SNIFF_MMIO_RDRSP_RESET_IGNORED] = 1'b1;
            if (!waiting[tid]) exp_vec[SNIFF_MMIO_RDRSP_UNSOLICITED] = 1'b1;
            else if (i - asked_at[tid] > MMIO_TIMEOUT) exp_vec[SNIFF_MMIO_RDRSP_TIMEOUT] = 1'b1;
            waiting[tid] = 1'b0;
         end
         if (b.c0_rx_mmio.mmio_rd_valid) begin
            tid           = int'(b.c0_rx_mmio.tid);
            waiting[tid]  = 1'b1;
            asked_at[tid] = i;
         end
      end
      // Requests still open when the list runs out
      for (int t = 0; t < 16; t++) begin
         if (waiting[t] && beats.size() - asked_at[t] > MMIO_TIMEOUT)
            exp_vec[SNIFF_MMIO_RDRSP_TIMEOUT] = 1'b1;
      end
      return exp_vec;
   endfunction

   function automatic t_ccip_claddr rand_addr();
      t_ccip_claddr a;
      a      = {10'($urandom), $urandom};
      // Four-line aligned, never line zero
      a[1:0] = 2'b00;
      a[6]   = 1'b1;
      return a;
   endfunction

   function automatic logic [1:0] rand_len();
      case ($urandom_range(2, 0))
         0: return CL_LEN_1;
         1: return CL_LEN_2;
         default: return CL_LEN_4;
      endcase
   endfunction

   function automatic string kind_name(int kind);
      case (kind)
         0: return "reqtype";
         1: return "3cl";
         2: return "align2";
         3: return "align4";
         4: return "addr_zero";
         5: return "overflow";
         default: return "reset_ignored";
      endcase
   endfunction

   task automatic push_read(t_ccip_claddr addr, logic [1:0] len, t_ccip_c0_req rtype);
      beat_t b;
      b                    = '0;
      b.c0_tx.valid        = 1'b1;
      b.c0_tx.hdr.cl_len   = t_ccip_cllen'(len);
      b.c0_tx.hdr.req_type = rtype;
      b.c0_tx.hdr.address  = addr;
      beats.push_back(b);
   endtask

   // Whole burst, address counting up one line per beat
   task automatic push_write(t_ccip_claddr addr, logic [1:0] len, t_ccip_c1_req wtype,
                             t_ccip_vc vc, logic sop);
      beat_t b;
      int    n;
      n = (len == CL_LEN_2) ? 2 : ((len == CL_LEN_4) ? 4 : 1);
      for (int i = 0; i < n; i++) begin
         b                    = '0;
         b.c1_tx.valid        = 1'b1;
         b.c1_tx.hdr.vc_sel   = vc;
         b.c1_tx.hdr.sop      = (i == 0) ? sop : 1'b0;
         b.c1_tx.hdr.cl_len   = t_ccip_cllen'(len);
         b.c1_tx.hdr.req_type = wtype;
         b.c1_tx.hdr.address  = addr + t_ccip_claddr'(i);
         beats.push_back(b);
      end
   endtask

   function automatic beat_t fence_beat();
      beat_t b;
      b                    = '0;
      b.c1_tx.valid        = 1'b1;
      b.c1_tx.hdr.req_type = WRFENCE;
      return b;
   endfunction

   task automatic push_mmio(logic [3:0] tid, logic is_rsp, logic in_reset);
      beat_t b;
      b                          = '0;
      b.soft_reset               = in_reset;
      b.c2_tx.mmio_rd_valid      = is_rsp;
      b.c2_tx.tid                = tid;
      b.c0_rx_mmio.mmio_rd_valid = !is_rsp;
      b.c0_rx_mmio.tid           = tid;
      beats.push_back(b);
   endtask

   task automatic push_idle(int n);
      repeat (n) beats.push_back(beat_t'('0));
   endtask

   task automatic drive_beat(beat_t b);
      @(negedge clk);
      soft_reset = b.soft_reset;
      c0_full    = b.c0_full;
      c1_full    = b.c1_full;
      c0_tx      = b.c0_tx;
      c1_tx      = b.c1_tx;
      c2_tx      = b.c2_tx;
      c0_rx_mmio = b.c0_rx_mmio;
   endtask

   // Clear, play the list, drain the report bus, then hand over for checking
   task automatic run_test(string name);
      int quiet;
      test_name = name;
      seen_codes.delete();
      @(negedge clk);
      init_sniffer = 1'b1;
      @(negedge clk);
      init_sniffer = 1'b0;
      collecting   = 1'b1;
      foreach (beats[i]) begin
         drive_beat(beats[i]);
      end
      drive_beat(beat_t'('0));
      quiet = 0;
      while (quiet < DRAIN_IDLE) begin
         @(negedge clk);
         quiet = report.valid ? 0 : quiet + 1;
      end
      collecting = 1'b0;
      -> test_done;
      @(test_checked);
      beats.delete();
   endtask

   task automatic legal_mix_test();
      t_ccip_claddr a;
      for (int i = 0; i < 16; i++) begin
         a = rand_addr();
         case ($urandom_range(3, 0))
            0: push_read(a, rand_len(), ($urandom_range(1, 0) != 0) ? RDLINE_S : RDLINE_I);
            1: push_write(a, CL_LEN_1, WRLINE_M, 2'($urandom), 1'b1);
            2: push_write(a, rand_len(), ($urandom_range(1, 0) != 0) ? WRPUSH_I : WRLINE_I,
                          2'($urandom), 1'b1);
            default: beats.push_back(fence_beat());
         endcase
         push_idle($urandom_range(2, 0));
      end
      run_test("legal_mix");
   endtask

   // One rule broken on an otherwise legal request
   task automatic single_beat_test(logic on_c1, int kind);
      t_ccip_claddr a;
      logic [1:0]   len;
      logic         bad_type;
      beat_t        b;
      a        = 42'h100;
      len      = CL_LEN_1;
      bad_type = 1'b0;
      case (kind)
         0: bad_type = 1'b1;
         1: len = CCIP_CLLEN_3;
         2: begin
            len = CL_LEN_2;
            a   = 42'h101;
         end
         3: begin
            len = CL_LEN_4;
            a   = 42'h102;
         end
         4: a = '0;
         default: ;
      endcase
      if (on_c1) begin
         push_write(a, len, bad_type ? t_ccip_c1_req'(4'h7) : WRLINE_I, 2'd1, 1'b1);
      end else begin
         push_read(a, len, bad_type ? t_ccip_c0_req'(4'h7) : RDLINE_I);
      end
      // Channel levels ride on the opening beat
      b            = beats[0];
      b.c0_full    = (kind == 5) && !on_c1;
      b.c1_full    = (kind == 5) && on_c1;
      b.soft_reset = (kind == 6);
      beats[0]     = b;
      run_test($sformatf("%s_%s", on_c1 ? "c1" : "c0", kind_name(kind)));
   endtask

   task automatic burst_tests();
      beat_t b;
      push_write(42'h200, CL_LEN_2, WRLINE_I, 2'd0, 1'b0);
      run_test("burst_sop_missing");
      push_write(42'h204, CL_LEN_4, WRLINE_M, 2'd0, 1'b1);
      b             = beats[2];
      b.c1_tx.hdr.sop = 1'b1;
      beats[2]      = b;
      run_test("burst_sop_mid");
      push_write(42'h208, CL_LEN_4, WRLINE_I, 2'd2, 1'b1);
      b                  = beats[1];
      b.c1_tx.hdr.vc_sel = 2'd3;
      beats[1]           = b;
      run_test("burst_vc_change");
      push_write(42'h20c, CL_LEN_2, WRLINE_I, 2'd1, 1'b1);
      b                    = beats[1];
      b.c1_tx.hdr.req_type = WRPUSH_I;
      beats[1]             = b;
      run_test("burst_reqtype_change");
      // Third beat repeats the base line instead of stepping
      push_write(42'h210, CL_LEN_4, WRPUSH_I, 2'd1, 1'b1);
      b                   = beats[2];
      b.c1_tx.hdr.address = 42'h210;
      beats[2]            = b;
      run_test("burst_addr_step");
      push_write(42'h214, CL_LEN_2, WRLINE_M, 2'd0, 1'b1);
      beats.insert(1, fence_beat());
      run_test("burst_fence_mid");
   endtask

   // C0, C1 and MMIO violations landing on one edge
   task automatic same_cycle_test();
      beat_t b;
      b                     = '0;
      b.soft_reset          = 1'b1;
      b.c1_full             = 1'b1;
      b.c0_tx.valid         = 1'b1;
      b.c0_tx.hdr.req_type  = RDLINE_I;
      b.c1_tx.valid         = 1'b1;
      b.c1_tx.hdr.sop       = 1'b1;
      b.c1_tx.hdr.req_type  = WRLINE_I;
      b.c1_tx.hdr.address   = 42'h300;
      b.c2_tx.mmio_rd_valid = 1'b1;
      b.c2_tx.tid           = 4'd12;
      beats.push_back(b);
      run_test("all_checkers_same_cycle");
   endtask

   task automatic mmio_tests();
      push_mmio(4'd2, 1'b0, 1'b0);
      push_idle(10);
      push_mmio(4'd2, 1'b1, 1'b0);
      run_test("mmio_answered");
      push_mmio(4'd7, 1'b1, 1'b0);
      run_test("mmio_unsolicited");
      push_mmio(4'd4, 1'b0, 1'b0);
      push_idle(3);
      push_mmio(4'd4, 1'b1, 1'b1);
      run_test("mmio_rsp_in_reset");
      // Left unanswered, so kept last
      push_mmio(4'd9, 1'b0, 1'b0);
      push_idle(2 * MMIO_TIMEOUT);
      run_test("mmio_timeout");
   endtask

   // Codes seen on the report bus, sampled away from the rising edge
   always @(negedge clk) begin
      if (collecting && report.valid) begin
         seen_codes.push_back(report.code);
      end
   end

   always begin : compare_results
      sniff_vec_t exp_vec;
      sniff_vec_t seen_vec;
      int         bad;
      @(test_done);
      exp_vec  = expected_codes();
      bad      = 0;
      seen_vec = '0;
      foreach (seen_codes[i]) begin
         seen_vec[seen_codes[i]] = 1'b1;
      end
      if (error_code !== exp_vec) begin
         $display("error: %s expected %h actual %h", test_name, exp_vec, error_code);
         bad = 1;
      end
      if (seen_vec !== exp_vec) begin
         $display("error: %s reported codes expected %h actual %h",
                  test_name, exp_vec, seen_vec);
         bad = 1;
      end
      if (seen_codes.size() != $countones(exp_vec)) begin
         $display("error: %s strobes expected %0d actual %0d",
                  test_name, $countones(exp_vec), seen_codes.size());
         bad = 1;
      end
      for (int i = 1; i < seen_codes.size(); i++) begin
         if (seen_codes[i] <= seen_codes[i-1]) begin
            $display("%s: report codes did not come in ascending order", test_name);
            bad = 1;
         end
      end
      tests_run++;
      tests_failed += bad;
      if (bad == 0) begin
         $display("test %s ok", test_name);
      end else begin
         $display("test %s wrong", test_name);
      end
      -> test_checked;
   end

   initial begin
      void'($urandom(SEED));
      clk          = 1'b0;
      ase_reset    = 1'b1;
      init_sniffer = 1'b0;
      soft_reset   = 1'b0;
      c0_full      = 1'b0;
      c1_full      = 1'b0;
      c0_tx        = '0;
      c1_tx        = '0;
      c2_tx        = '0;
      c0_rx_mmio   = '0;
      collecting   = 1'b0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (RESET_CYCLES) @(negedge clk);
      ase_reset = 1'b0;

      legal_mix_test();
      for (int ch = 0; ch < 2; ch++) begin
         for (int k = 0; k < 7; k++) begin
            single_beat_test(ch == 1, k);
         end
      end
      burst_tests();
      same_cycle_test();
      mmio_tests();

      $display("%0d tests run, %0d wrong, %0d assertion failures",
               tests_run, tests_failed, dut_i.props_i.assert_fails);
      if (tests_failed == 0 && tests_run == NUM_TESTS && dut_i.props_i.assert_fails == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Hard stop well past the expected run length
   initial begin
      #(RUN_LIMIT);
      $display("watchdog: run still going after %0d ns, stopping", RUN_LIMIT);
      $display("Checks failed");
      $finish;
   end

endmodule
